//--- flist.f
+incdir+.
t04_pkg.sv
t04_screenIf.sv
t04_keypadScan.sv
t04_mmio.sv
t04_screenWriter.sv
t04_top.sv
tb_t04_top.sv

//--- t04_keypadScan.sv
`include "t04_macros.svh"

module t04_keypadScan (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic [3:0]            row,
  output logic [3:0]            column,
  output logic                  keyStrobe,
  output t04_pkg::t04_keyCode_t keyCode,
  output logic [4:0]            button
);
  import t04_pkg::*;

  localparam int SlotW = $clog2(`T04_SCAN_CYCLES);
  localparam int DebW  = $clog2(`T04_DEBOUNCE_COUNT + 1);

  logic [SlotW-1:0] slotCnt;
  logic [1:0]       colIdx;
  logic             scanning;
  logic             slotEnd;
  logic             rowHit;
  logic [1:0]       rowIdx;
  logic             roundHit;
  t04_keyCode_t     roundCode;
  logic             hitNow;
  t04_keyCode_t     codeNow;
  t04_keyCode_t     candCode;
  logic [DebW-1:0]  stableCnt;
  logic             armed;

  assign slotEnd = (slotCnt == SlotW'(`T04_SCAN_CYCLES - 1));
  // rows are pulled low by a pressed key
  assign rowHit  = scanning && (row != 4'hF);

  // lowest pressed row wins
  always_comb begin
    rowIdx = 2'd0;
    for (int i = 3; i >= 0; i--) begin
      if (!row[i]) begin
        rowIdx = 2'(i);
      end
    end
  end

  // first key seen this round, including the slot ending now
  assign hitNow  = roundHit || rowHit;
  assign codeNow = roundHit ? roundCode : {colIdx, rowIdx};

  // column walk, one slot per column
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      slotCnt  <= '0;
      colIdx   <= 2'd3;
      scanning <= 1'b0;
      column   <= 4'hF;
    end else if (!scanning || slotEnd) begin
      slotCnt  <= '0;
      colIdx   <= colIdx + 2'd1;
      scanning <= 1'b1;
      column   <= ~(4'b0001 << (colIdx + 2'd1));
    end else begin
      slotCnt <= slotCnt + 1'b1;
    end
  end

  // round result feeds the debouncer at the last column
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      roundHit  <= 1'b0;
      roundCode <= '0;
      candCode  <= '0;
      stableCnt <= '0;
      armed     <= 1'b1;
      keyStrobe <= 1'b0;
      keyCode   <= '0;
    end else begin
      keyStrobe <= 1'b0;
      if (scanning && slotEnd) begin
        if (colIdx != 2'd3) begin
          roundHit  <= hitNow;
          roundCode <= codeNow;
        end else begin
          roundHit <= 1'b0;
          if (!armed) begin
            // rearm only after a round with nothing down
            armed <= !hitNow;
          end else if (!hitNow) begin
            stableCnt <= '0;
          end else if (stableCnt != '0 && codeNow == candCode) begin
            if (stableCnt == DebW'(`T04_DEBOUNCE_COUNT - 1)) begin
              keyStrobe <= 1'b1;
              keyCode   <= candCode;
              armed     <= 1'b0;
              stableCnt <= '0;
            end else begin
              stableCnt <= stableCnt + 1'b1;
            end
          end else begin
            // new candidate, start counting again
            candCode  <= codeNow;
            stableCnt <= DebW'(1);
          end
        end
      end
    end
  end

  // held flag above the latest code
  assign button = {!armed, keyCode};

  // once scanning, exactly one column is low
  assert property (@(posedge clk) disable iff (!arstN) scanning |-> $onehot(~column));
  // one strobe per press
  assert property (@(posedge clk) disable iff (!arstN) keyStrobe |=> !keyStrobe);

endmodule

//--- t04_macros.svh
`ifndef T04_MACROS_SVH
`define T04_MACROS_SVH

// cycles each keypad column stays driven low
`define T04_SCAN_CYCLES 16

// matching scan rounds needed before a press counts
`define T04_DEBOUNCE_COUNT 3

// wrx low time, then high time, per byte
`define T04_WR_PHASE 2

// screen operation queue entries
`define T04_QUEUE_DEPTH 4

// register offsets on the AXI4-Lite port
`define T04_ADDR_W 8
`define T04_ADDR_STATUS 8'h00
`define T04_ADDR_KEY 8'h04
`define T04_ADDR_BYTE 8'h08
`define T04_ADDR_FILL 8'h0C

`endif

//--- t04_mmio.sv
`include "t04_macros.svh"

module t04_mmio (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic [`T04_ADDR_W-1:0] awaddr,
  input  logic                   awvalid,
  output logic                   awready,
  input  logic [31:0]            wdata,
  input  logic [3:0]             wstrb,
  input  logic                   wvalid,
  output logic                   wready,
  output logic [1:0]             bresp,
  output logic                   bvalid,
  input  logic                   bready,
  input  logic [`T04_ADDR_W-1:0] araddr,
  input  logic                   arvalid,
  output logic                   arready,
  output logic [31:0]            rdata,
  output logic [1:0]             rresp,
  output logic                   rvalid,
  input  logic                   rready,
  input  logic                   keyStrobe,
  input  t04_pkg::t04_keyCode_t  keyCode,
  input  logic                   screenBusy,
  t04_screenIf.source            scr
);
  import t04_pkg::*;

  localparam int QDepth = `T04_QUEUE_DEPTH;
  localparam int PtrW   = (QDepth > 1) ? $clog2(QDepth) : 1;
  localparam int CntW   = $clog2(QDepth + 1);
  localparam logic [1:0] RespOkay = 2'b00;
  localparam logic [1:0] RespSlvErr = 2'b10;

  t04_screenOp_t   queueMem [QDepth];
  logic [PtrW-1:0] wrPtr;
  logic [PtrW-1:0] rdPtr;
  logic [CntW-1:0] qCount;
  logic            qFull;
  logic            qPush;
  logic            qPop;
  logic            wrIsQueue;
  logic            wrAccept;
  logic            wrErr;
  logic [31:0]     strbMask;
  t04_screenWord_u wrWord;
  t04_screenOp_t   newOp;
  logic            rdAccept;
  logic            keyValid;
  t04_keyCode_t    keyHeld;

  assign qFull = (qCount == CntW'(QDepth));

  // unstrobed bytes read as zero
  assign strbMask = {{8{wstrb[3]}}, {8{wstrb[2]}}, {8{wstrb[1]}}, {8{wstrb[0]}}};
  assign wrWord   = wdata & strbMask;

  assign wrIsQueue = (awaddr == `T04_ADDR_BYTE) || (awaddr == `T04_ADDR_FILL);
  // full queue only stalls queue registers
  assign wrAccept  = awvalid && wvalid && !bvalid && (!qFull || !wrIsQueue);
  assign awready   = wrAccept;
  assign wready    = wrAccept;

  // write decode, word seen through the union views
  always_comb begin
    newOp = '0;
    qPush = 1'b0;
    wrErr = 1'b1;
    case (awaddr)
      `T04_ADDR_BYTE: begin
        wrErr      = 1'b0;
        newOp.cmd  = wrWord.byteView.cmd;
        newOp.data = wrWord.byteView.data;
        newOp.count = 16'd1;
        qPush      = wrAccept;
      end
      `T04_ADDR_FILL: begin
        wrErr       = 1'b0;
        newOp.data  = wrWord.fillView.data;
        newOp.count = wrWord.fillView.count;
        // zero count is a no-op
        qPush       = wrAccept && (wrWord.fillView.count != 16'd0);
      end
      default: wrErr = 1'b1;
    endcase
  end

  // write response channel
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      bvalid <= 1'b0;
      bresp  <= RespOkay;
    end else if (wrAccept) begin
      bvalid <= 1'b1;
      bresp  <= wrErr ? RespSlvErr : RespOkay;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  // circular queue toward the writer
  assign qPop      = scr.valid && scr.ready;
  assign scr.valid = (qCount != '0);
  assign scr.op    = queueMem[rdPtr];

  always_ff @(posedge clk) begin
    if (qPush) begin
      queueMem[wrPtr] <= newOp;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wrPtr  <= '0;
      rdPtr  <= '0;
      qCount <= '0;
    end else begin
      if (qPush) begin
        wrPtr <= (wrPtr == PtrW'(QDepth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (qPop) begin
        rdPtr <= (rdPtr == PtrW'(QDepth - 1)) ? '0 : rdPtr + 1'b1;
      end
      qCount <= qCount + CntW'(qPush) - CntW'(qPop);
    end
  end

  // read channel
  assign arready  = !rvalid;
  assign rdAccept = arvalid && arready;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      rvalid <= 1'b0;
      rresp  <= RespOkay;
      rdata  <= '0;
    end else if (rdAccept) begin
      rvalid <= 1'b1;
      rresp  <= RespOkay;
      case (araddr)
        `T04_ADDR_STATUS: rdata <= {24'd0, keyHeld, 1'b0, screenBusy, qFull, keyValid};
        `T04_ADDR_KEY:    rdata <= {27'd0, keyValid, keyHeld};
        default: begin
          rdata <= '0;
          rresp <= RespSlvErr;
        end
      endcase
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  // newest key wins over a clearing KEY read
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      keyValid <= 1'b0;
      keyHeld  <= '0;
    end else if (keyStrobe) begin
      keyValid <= 1'b1;
      keyHeld  <= keyCode;
    end else if (rdAccept && araddr == `T04_ADDR_KEY) begin
      keyValid <= 1'b0;
    end
  end

  // responses hold until taken
  assert property (@(posedge clk) disable iff (!arstN)
    bvalid && !bready |=> bvalid && $stable(bresp));
  assert property (@(posedge clk) disable iff (!arstN)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));
  // occupancy stays within depth
  assert property (@(posedge clk) disable iff (!arstN) qCount <= CntW'(QDepth));

endmodule

//--- t04_pkg.sv
package t04_pkg;

  // column index * 4 + row index
  typedef logic [3:0] t04_keyCode_t;

  // BYTE register layout
  typedef struct packed {
    logic [22:0] rsvd;
    logic        cmd;
    logic [7:0]  data;
  } t04_byteView_t;

  // FILL register layout
  typedef struct packed {
    logic [15:0] count;
    logic [7:0]  rsvd;
    logic [7:0]  data;
  } t04_fillView_t;

  // one write word, read either as a single byte or as a fill
  typedef union packed {
    t04_byteView_t byteView;
    t04_fillView_t fillView;
  } t04_screenWord_u;

  // queued screen work
  // count of 1 for a single byte
  typedef struct packed {
    logic        cmd;
    logic [7:0]  data;
    logic [15:0] count;
  } t04_screenOp_t;

endpackage

//--- t04_screenIf.sv
interface t04_screenIf;
  import t04_pkg::*;

  // op moves when valid and ready are both high
  logic          valid;
  logic          ready;
  t04_screenOp_t op;

  // register block side
  modport source (
    output valid,
    output op,
    input  ready
  );

  // lcd writer side
  modport sink (
    input  valid,
    input  op,
    output ready
  );

endinterface

//--- t04_screenWriter.sv
`include "t04_macros.svh"

module t04_screenWriter (
  input  logic      clk,
  input  logic      arstN,
  t04_screenIf.sink scr,
  output logic      screenBusy,
  output logic      screenCsx,
  output logic      screenDcx,
  output logic      screenWrx,
  output logic [7:0] screenData
);
  import t04_pkg::*;

  localparam int PhW = (`T04_WR_PHASE > 1) ? $clog2(`T04_WR_PHASE) : 1;
  localparam logic [1:0] StIdle  = 2'd0;
  localparam logic [1:0] StSetup = 2'd1;
  localparam logic [1:0] StLow   = 2'd2;
  localparam logic [1:0] StHigh  = 2'd3;

  logic [1:0]     state;
  logic [PhW-1:0] phaseCnt;
  logic           phaseEnd;
  logic [15:0]    remaining;

  assign phaseEnd = (phaseCnt == PhW'(`T04_WR_PHASE - 1));

  // take new work only when idle
  assign scr.ready  = (state == StIdle);
  assign screenBusy = (state != StIdle);
  // port strobes decoded from state
  assign screenCsx  = (state == StIdle);
  assign screenWrx  = (state != StLow);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state     <= StIdle;
      phaseCnt  <= '0;
      remaining <= '0;
    end else begin
      case (state)
        StIdle: begin
          if (scr.valid) begin
            remaining <= scr.op.count;
            state     <= StSetup;
          end
        end
        // csx low one cycle before the first wrx fall
        StSetup: begin
          phaseCnt <= '0;
          state    <= StLow;
        end
        StLow: begin
          if (phaseEnd) begin
            phaseCnt <= '0;
            state    <= StHigh;
          end else begin
            phaseCnt <= phaseCnt + 1'b1;
          end
        end
        StHigh: begin
          if (phaseEnd) begin
            phaseCnt <= '0;
            // last byte ends the operation
            if (remaining <= 16'd1) begin
              state <= StIdle;
            end else begin
              remaining <= remaining - 16'd1;
              state     <= StLow;
            end
          end else begin
            phaseCnt <= phaseCnt + 1'b1;
          end
        end
        default: state <= StIdle;
      endcase
    end
  end

  // byte and dc level, latched once per operation
  always_ff @(posedge clk) begin
    if (scr.valid && scr.ready) begin
      screenData <= scr.op.data;
      screenDcx  <= !scr.op.cmd;
    end
  end

  // panel latches on wrx rise, bus must be quiet while low
  assert property (@(posedge clk) disable iff (!arstN)
    !screenWrx |-> $stable(screenData) && $stable(screenDcx));

endmodule

//--- t04_top.sv
`include "t04_macros.svh"

module t04_top (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic [`T04_ADDR_W-1:0] awaddr,
  input  logic                   awvalid,
  output logic                   awready,
  input  logic [31:0]            wdata,
  input  logic [3:0]             wstrb,
  input  logic                   wvalid,
  output logic                   wready,
  output logic [1:0]             bresp,
  output logic                   bvalid,
  input  logic                   bready,
  input  logic [`T04_ADDR_W-1:0] araddr,
  input  logic                   arvalid,
  output logic                   arready,
  output logic [31:0]            rdata,
  output logic [1:0]             rresp,
  output logic                   rvalid,
  input  logic                   rready,
  input  logic [3:0]             row,
  output logic [3:0]             column,
  output logic [4:0]             button,
  output logic                   screenCsx,
  output logic                   screenDcx,
  output logic                   screenWrx,
  output logic [7:0]             screenData
);
  import t04_pkg::*;

  // keypad to register block
  logic         keyStrobe;
  t04_keyCode_t keyCode;
  logic         screenBusy;

  // queued screen operations
  t04_screenIf scrIf ();

  t04_keypadScan u_keypadScan (
    .clk       (clk),
    .arstN     (arstN),
    .row       (row),
    .column    (column),
    .keyStrobe (keyStrobe),
    .keyCode   (keyCode),
    .button    (button)
  );

  t04_mmio u_mmio (
    .clk        (clk),
    .arstN      (arstN),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .wready     (wready),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .bready     (bready),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .rready     (rready),
    .keyStrobe  (keyStrobe),
    .keyCode    (keyCode),
    .screenBusy (screenBusy),
    .scr        (scrIf.source)
  );

  t04_screenWriter u_screenWriter (
    .clk        (clk),
    .arstN      (arstN),
    .scr        (scrIf.sink),
    .screenBusy (screenBusy),
    .screenCsx  (screenCsx),
    .screenDcx  (screenDcx),
    .screenWrx  (screenWrx),
    .screenData (screenData)
  );

endmodule

//--- tb_t04_top.sv
`include "t04_macros.svh"

module tb_t04_top;

  localparam int RoundCycles   = 4 * `T04_SCAN_CYCLES;
  localparam int KeyCycles     = RoundCycles * (`T04_DEBOUNCE_COUNT + 1);
  localparam int NumKeys       = 2;
  localparam int NumByteWrites = 6;
  localparam int NumFills      = 4;
  localparam int MaxFill       = 6;
  localparam int NumStallFills = 7;
  localparam int MaxStallFill  = 8;
  localparam int MaxBytes      = NumByteWrites + NumFills * MaxFill + NumStallFills * MaxStallFill;
  // idle and setup cycles on top of each byte
  localparam int OpCycles      = 2 * `T04_WR_PHASE + 2;
  localparam int CycleLimit    = NumKeys * (KeyCycles + 5 * RoundCycles)
                               + MaxBytes * OpCycles + 2000;
  localparam int DrainLimit    = MaxBytes * OpCycles;
  localparam int KindScreen    = 0;
  localparam int KindBus       = 1;
  localparam int KindKey       = 2;
  localparam int KindProto     = 3;
  localparam logic [1:0] Okay   = 2'b00;
  localparam logic [1:0] SlvErr = 2'b10;

  logic                   clk;
  logic                   arstN;
  logic [`T04_ADDR_W-1:0] awaddr;
  logic                   awvalid;
  logic                   awready;
  logic [31:0]            wdata;
  logic [3:0]             wstrb;
  logic                   wvalid;
  logic                   wready;
  logic [1:0]             bresp;
  logic                   bvalid;
  logic                   bready;
  logic [`T04_ADDR_W-1:0] araddr;
  logic                   arvalid;
  logic                   arready;
  logic [31:0]            rdata;
  logic [1:0]             rresp;
  logic                   rvalid;
  logic                   rready;
  logic [3:0]             row;
  logic [3:0]             column;
  logic [4:0]             button;
  logic                   screenCsx;
  logic                   screenDcx;
  logic                   screenWrx;
  logic [7:0]             screenData;

  // keypad model state
  logic       keyDown;
  logic [1:0] keyCol;
  logic [1:0] keyRow;

  // expected {dcx, data} per wrx rise
  logic [8:0] expQ[$];
  logic [8:0] expEntry;
  logic       wrxLast = 1'b1;
  int         bytesSeen = 0;
  int         errCnt[4] = '{default: 0};
  int         cycles;

  t04_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic logMismatch(input int kind, input string msg);
    errCnt[kind]++;
    $display("** Error @ %0t: %s", $time, msg);
  endtask

  task automatic raiseProblem(input int kind, input string msg);
    errCnt[kind]++;
    $display("problem at time %0t: %s", $time, msg);
  endtask

  task automatic axiWrite(input logic [7:0] addr, input logic [31:0] data,
                          output logic [1:0] resp, output int stall);
    stall = 0;
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= 4'hF;
    wvalid  <= 1'b1;
    @(posedge clk);
    while (!(awready && wready)) begin
      stall++;
      @(posedge clk);
    end
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    bready  <= 1'b1;
    @(posedge clk);
    while (!bvalid) @(posedge clk);
    resp = bresp;
    bready <= 1'b0;
  endtask

  task automatic axiRead(input logic [7:0] addr, output logic [31:0] data,
                         output logic [1:0] resp);
    araddr  <= addr;
    arvalid <= 1'b1;
    @(posedge clk);
    while (!arready) @(posedge clk);
    arvalid <= 1'b0;
    rready  <= 1'b1;
    @(posedge clk);
    while (!rvalid) @(posedge clk);
    data = rdata;
    resp = rresp;
    rready <= 1'b0;
  endtask

  task automatic checkResp(input string what, input logic [1:0] got, input logic [1:0] exp);
    assert (got == exp) else
      logMismatch(KindBus, $sformatf("%s: resp %b, expected %b", what, got, exp));
  endtask

  // fill word, reserved bits carry junk
  task automatic queueFill(input logic [7:0] data, input int count, output int stall);
    logic [1:0] rsp;
    for (int i = 0; i < count; i++) expQ.push_back({1'b1, data});
    axiWrite(`T04_ADDR_FILL, {16'(count), 8'($urandom), data}, rsp, stall);
    checkResp("FILL write", rsp, Okay);
  endtask

  // wait for scoreboard empty, then writer idle
  task automatic waitScreenIdle(input string phase);
    logic [31:0] st;
    logic [1:0]  rsp;
    int          n;
    n = 0;
    while (expQ.size() != 0 && n < DrainLimit) begin
      @(posedge clk);
      n++;
    end
    if (expQ.size() != 0) begin
      raiseProblem(KindScreen, $sformatf("%s: %0d bytes never reached the screen",
                                         phase, expQ.size()));
    end
    expQ.delete();
    n = 0;
    do begin
      axiRead(`T04_ADDR_STATUS, st, rsp);
      n++;
    end while (st[2] && n < 20);
    assert (st[2:1] == 2'b00) else
      logMismatch(KindScreen, $sformatf("%s: status busy/full %b after drain", phase, st[2:1]));
  endtask

  // press, read back, hold, release
  task automatic checkKey(input int c, input int r);
    logic [31:0] rd;
    logic [1:0]  rsp;
    logic [3:0]  code;
    int          polls;
    code = 4'(c * 4 + r);
    keyCol  <= 2'(c);
    keyRow  <= 2'(r);
    keyDown <= 1'b1;
    polls = 0;
    do begin
      axiRead(`T04_ADDR_STATUS, rd, rsp);
      polls++;
    end while (!rd[0] && polls < KeyCycles);
    if (!rd[0]) begin
      raiseProblem(KindKey, $sformatf("key at column %0d row %0d was never reported", c, r));
    end else begin
      assert (rd[7:4] == code) else
        logMismatch(KindKey, $sformatf("status key code %0d, expected %0d", rd[7:4], code));
    end
    axiRead(`T04_ADDR_KEY, rd, rsp);
    checkResp("KEY read", rsp, Okay);
    assert (rd[4:0] == {1'b1, code}) else
      logMismatch(KindKey, $sformatf("KEY read %h, expected %h", rd[4:0], {1'b1, code}));
    axiRead(`T04_ADDR_STATUS, rd, rsp);
    assert (!rd[0]) else logMismatch(KindKey, "keyValid still set after KEY read");
    // still held, must not report again
    repeat (3 * RoundCycles) @(posedge clk);
    axiRead(`T04_ADDR_STATUS, rd, rsp);
    assert (!rd[0]) else logMismatch(KindKey, "held key set keyValid a second time");
    // pressed flag up while held
    assert (button == {1'b1, code}) else
      logMismatch(KindKey, $sformatf("button %b while held, expected %b",
                  button, {1'b1, code}));
    keyDown <= 1'b0;
    repeat (2 * RoundCycles) @(posedge clk);
    // flag drops after a clear round, code kept
    assert (button == {1'b0, code}) else
      logMismatch(KindKey, $sformatf("button %b after release, expected %b",
                  button, {1'b0, code}));
  endtask

  // row pulled low while its column is driven
  always @(posedge clk) begin
    row <= (keyDown && !column[keyCol]) ? ~(4'b0001 << keyRow) : 4'hF;
  end

  // panel side, one byte per wrx rise
  always @(posedge clk) begin
    if (arstN && !wrxLast && screenWrx) begin
      bytesSeen++;
      if (expQ.size() == 0) begin
        raiseProblem(KindScreen, "wrx rose with no byte expected");
      end else begin
        expEntry = expQ.pop_front();
        assert ({screenDcx, screenData} == expEntry) else
          logMismatch(KindScreen, $sformatf("dcx/data %b/%h, expected %b/%h",
                      screenDcx, screenData, expEntry[8], expEntry[7:0]));
      end
    end
    wrxLast = screenWrx;
  end

  // reset values
  assert property (@(posedge clk) $rose(arstN) |->
    screenCsx && screenWrx && !bvalid && !rvalid && arready && !awready && !wready)
    else logMismatch(KindProto, "outputs not at reset values after reset");
  assert property (@(posedge clk) disable iff (!arstN) awready == wready)
    else logMismatch(KindProto, "awready and wready differ");
  // one cycle from acceptance to response
  assert property (@(posedge clk) disable iff (!arstN) awvalid && awready |=> bvalid)
    else logMismatch(KindProto, "bvalid late after write acceptance");
  assert property (@(posedge clk) disable iff (!arstN) arvalid && arready |=> rvalid)
    else logMismatch(KindProto, "rvalid late after read acceptance");
  assert property (@(posedge clk) disable iff (!arstN) !screenWrx |-> !screenCsx)
    else logMismatch(KindProto, "wrx low while csx high");

  initial begin
    cycles = 0;
    while (cycles < CycleLimit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: test did not finish within %0d cycles", CycleLimit);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    logic [31:0] rd;
    logic [31:0] wd;
    logic [1:0]  rsp;
    int          stall;
    int          stallSum;
    int          startSeen;
    int          expectSum;
    int          n;
    void'($urandom(32'h8c6c));
    arstN   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    row     = 4'hF;
    keyDown = 1'b0;
    keyCol  = 2'd0;
    keyRow  = 2'd0;
    repeat (5) @(posedge clk);
    arstN <= 1'b1;
    @(posedge clk);

    // idle status
    axiRead(`T04_ADDR_STATUS, rd, rsp);
    checkResp("STATUS read", rsp, Okay);
    assert (rd[2:0] == 3'b000) else
      logMismatch(KindBus, $sformatf("status after reset %b, expected 000", rd[2:0]));

    // error responses
    axiWrite(8'h10, 32'hDEAD_BEEF, rsp, stall);
    checkResp("write to unknown address", rsp, SlvErr);
    axiWrite(`T04_ADDR_STATUS, 32'h0000_00FF, rsp, stall);
    checkResp("write to STATUS", rsp, SlvErr);
    axiWrite(`T04_ADDR_KEY, 32'h0000_001F, rsp, stall);
    checkResp("write to KEY", rsp, SlvErr);
    axiRead(8'h20, rd, rsp);
    checkResp("read of unknown address", rsp, SlvErr);
    axiRead(`T04_ADDR_KEY, rd, rsp);
    checkResp("KEY read", rsp, Okay);

    checkKey(1, 2);
    checkKey(3, 0);

    // single bytes, upper bits random junk
    startSeen = bytesSeen;
    for (int i = 0; i < NumByteWrites; i++) begin
      wd = $urandom;
      expQ.push_back({!wd[8], wd[7:0]});
      axiWrite(`T04_ADDR_BYTE, wd, rsp, stall);
      checkResp("BYTE write", rsp, Okay);
    end
    waitScreenIdle("byte writes");
    assert (bytesSeen - startSeen == NumByteWrites) else
      logMismatch(KindScreen, $sformatf("saw %0d bytes, expected %0d",
                  bytesSeen - startSeen, NumByteWrites));

    // fills, then a zero count
    startSeen = bytesSeen;
    expectSum = 0;
    for (int i = 0; i < NumFills; i++) begin
      n = $urandom_range(MaxFill, 1);
      expectSum += n;
      queueFill(8'($urandom), n, stall);
    end
    queueFill(8'($urandom), 0, stall);
    waitScreenIdle("fill writes");
    assert (bytesSeen - startSeen == expectSum) else
      logMismatch(KindScreen, $sformatf("fill bytes %0d, expected %0d",
                  bytesSeen - startSeen, expectSum));

    // more fills than the queue holds
    startSeen = bytesSeen;
    expectSum = 0;
    stallSum  = 0;
    for (int i = 0; i < NumStallFills; i++) begin
      n = $urandom_range(MaxStallFill, 3);
      expectSum += n;
      queueFill(8'($urandom), n, stall);
      stallSum += stall;
    end
    assert (stallSum > 0) else
      raiseProblem(KindBus, "awready never stalled with the queue full");
    waitScreenIdle("back-to-back fills");
    assert (bytesSeen - startSeen == expectSum) else
      logMismatch(KindScreen, $sformatf("stalled fill bytes %0d, expected %0d",
                  bytesSeen - startSeen, expectSum));

    repeat (4) @(posedge clk);
    $display("error counts: screen %0d, bus %0d, key %0d, protocol %0d",
             errCnt[KindScreen], errCnt[KindBus], errCnt[KindKey], errCnt[KindProto]);
    if (errCnt.sum() == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
